//--- Bender.yml
package:
  name: memory_data_dispatcher

sources:
  - include_dirs:
      - hw
    files:
      - hw/dispatch_pkg.sv
      - hw/sample_stream_if.sv
      - hw/burst_counter.sv
      - hw/dispatch_fsm.sv
      - hw/banked_sample_mem.sv
      - hw/memory_data_dispatcher.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_memory_data_dispatcher.sv

//--- hw/banked_sample_mem.sv
`timescale 1ns/1ps

`include "dispatch_consts.svh"

module banked_sample_mem #(
    parameter int unsigned N_MEM = `DISP_N_MEM
) (
    input  logic                       i_clk,
    input  logic                       i_wr_en,
    input  logic [$clog2(N_MEM)-1:0]   i_wr_sel,
    input  dispatch_pkg::addr_t        i_wr_addr,
    input  dispatch_pkg::word_t        i_wr_data,
    input  dispatch_pkg::addr_t        i_rd_addr,
    sample_stream_if.mem               o_stream
);

    localparam int unsigned NB_WORD = $bits(dispatch_pkg::word_t);
    localparam int unsigned NB_SEL  = $clog2(N_MEM);
    localparam int unsigned DEPTH   = 1 << $bits(dispatch_pkg::addr_t);

    dispatch_pkg::word_t              rd_q [N_MEM];
    logic [N_MEM-1:0][NB_WORD-1:0]    rd_data;

    // ************************************************************************
    // Elaboration checks
    // ************************************************************************

    if ((N_MEM == 0) || ((N_MEM & (N_MEM - 1)) != 0)) begin : g_check_pow2
        $fatal(1, "banked_sample_mem: N_MEM must be a power of two");
    end

    if (N_MEM * NB_WORD != $bits(dispatch_pkg::sample_t)) begin : g_check_width
        $fatal(1, "banked_sample_mem: N_MEM does not match the sample width");
    end

    // ************************************************************************
    // Banks
    // ************************************************************************

    for (genvar g = 0; g < N_MEM; g++) begin : g_bank
        dispatch_pkg::word_t bank [DEPTH];

        always_ff @(posedge i_clk) begin
            if (i_wr_en && (i_wr_sel == NB_SEL'(g))) begin
                bank[i_wr_addr] <= i_wr_data;              // Each bank written on its own
            end
            rd_q[g] <= bank[i_rd_addr];                    // All banks read every cycle
        end
    end

    always_comb begin
        for (int b = 0; b < N_MEM; b++) begin
            rd_data[b] = rd_q[b];                          // Bank 0 in the low word
        end
    end

    assign o_stream.data = rd_data;

    a_wr_sel_known : assert property (
        @(posedge i_clk)
        i_wr_en |-> !$isunknown(i_wr_sel)
    ) else $error("banked_sample_mem: write with an unknown bank select");

endmodule

//--- hw/burst_counter.sv
`timescale 1ns/1ps

module burst_counter #(
    parameter int unsigned NB_COUNT = $bits(dispatch_pkg::count_t)
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_start,
    input  logic                i_enable,
    input  logic [NB_COUNT-1:0] i_max_count,
    output logic [NB_COUNT-1:0] o_count,
    output logic                o_step,
    output logic                o_done,
    output logic                o_busy
);

    logic [NB_COUNT-1:0] count;
    logic                busy;

    assign o_step  = busy & i_enable;                      // One burst position per step
    assign o_done  = o_step & (count == i_max_count);
    assign o_count = count;
    assign o_busy  = busy;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (i_start) begin
            count <= '0;                                   // Loads even while paused
            busy  <= 1'b1;
        end else if (o_step) begin
            if (count == i_max_count) begin
                busy <= 1'b0;                              // Count rests on the maximum
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // The maximum comes from a descriptor held for the whole burst
    a_count_in_range : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_busy |-> (o_count <= i_max_count)
    ) else $error("burst_counter: count %0d above max %0d", o_count, i_max_count);

endmodule

//--- hw/dispatch_consts.svh
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// ****************************************************************************
// Dispatcher sizes
// ****************************************************************************

// A burst holds len+1 words
`define DISP_NB_LEN 6

// Depth is 2**DISP_NB_ADDR and must cover the longest burst
`define DISP_NB_ADDR 6

`define DISP_NB_WORD 8        // One bank word

`define DISP_N_MEM 2          // Bank count must be a power of two

`define DISP_NB_BANK_SEL $clog2(`DISP_N_MEM)

`endif

//--- hw/dispatch_fsm.sv
`timescale 1ns/1ps

module dispatch_fsm (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_enable,
    input  logic                      i_desc_valid,
    input  logic                      i_desc_skip,
    input  dispatch_pkg::descriptor_t i_desc,
    output logic                      o_desc_ready,
    output dispatch_pkg::addr_t       o_rd_addr,
    output logic                      o_cnt_start,
    output dispatch_pkg::count_t      o_cnt_max,
    input  dispatch_pkg::count_t      i_cnt_value,
    input  logic                      i_cnt_step,
    input  logic                      i_cnt_done,
    input  logic                      i_cnt_busy,
    sample_stream_if.ctrl             o_stream
);

    dispatch_pkg::state_t      state;
    dispatch_pkg::descriptor_t desc_q;
    logic                      start_q;
    logic                      load;

    // ************************************************************************
    // Descriptor acceptance
    // ************************************************************************

    // Ready stays low through the final word so bursts never touch
    assign o_desc_ready = (state == dispatch_pkg::IDLE) & i_enable & ~o_stream.last;
    assign load         = i_desc_valid & o_desc_ready & ~i_desc_skip;  // Skipped ones vanish

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= dispatch_pkg::IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                dispatch_pkg::IDLE: begin
                    if (load) begin
                        state   <= dispatch_pkg::RUN;
                        start_q <= 1'b1;
                    end
                end
                dispatch_pkg::RUN: begin
                    if (i_cnt_done) begin
                        state <= dispatch_pkg::IDLE;
                    end
                end
                default: state <= dispatch_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            desc_q <= i_desc;
        end
    end

    // ************************************************************************
    // Counter control, read address and stream flags
    // ************************************************************************

    assign o_cnt_start = start_q;
    assign o_cnt_max   = dispatch_pkg::count_t'(desc_q.len);
    assign o_rd_addr   = desc_q.base_addr + dispatch_pkg::addr_t'(i_cnt_value);  // Wraps

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_stream.valid <= 1'b0;
            o_stream.last  <= 1'b0;
            o_stream.count <= '0;
        end else begin
            o_stream.valid <= i_cnt_step;                  // Aligned with the registered read
            o_stream.last  <= i_cnt_done;
            o_stream.count <= i_cnt_value;
        end
    end

    a_start_when_free : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_cnt_start |-> !i_cnt_busy
    ) else $error("dispatch_fsm: start while the counter is still busy");

endmodule

//--- hw/dispatch_pkg.sv
`include "dispatch_consts.svh"

package dispatch_pkg;

    typedef logic [`DISP_NB_LEN-1:0]  len_t;
    typedef logic [`DISP_NB_ADDR-1:0] addr_t;
    typedef logic [`DISP_NB_LEN:0]    count_t;    // One bit above len_t
    typedef logic [`DISP_NB_WORD-1:0] word_t;

    // Bank 0 lands in the least significant word
    typedef logic [`DISP_N_MEM-1:0][`DISP_NB_WORD-1:0] sample_t;

    typedef struct packed {
        len_t  len;
        addr_t base_addr;
    } descriptor_t;

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

endpackage

//--- hw/memory_data_dispatcher.sv
`timescale 1ns/1ps

`include "dispatch_consts.svh"

module memory_data_dispatcher (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_enable,
    input  logic                          i_desc_valid,
    input  logic                          i_desc_skip,
    input  dispatch_pkg::len_t            i_desc_len,
    input  dispatch_pkg::addr_t           i_desc_base,
    output logic                          o_desc_ready,
    input  logic                          i_wr_en,
    input  logic [`DISP_NB_BANK_SEL-1:0]  i_wr_sel,
    input  dispatch_pkg::addr_t           i_wr_addr,
    input  dispatch_pkg::word_t           i_wr_data,
    output dispatch_pkg::sample_t         o_data,
    output logic                          o_valid,
    output logic                          o_last,
    output dispatch_pkg::count_t          o_count_value
);

    dispatch_pkg::descriptor_t desc;
    dispatch_pkg::addr_t       rd_addr;
    dispatch_pkg::count_t      cnt_max;
    dispatch_pkg::count_t      cnt_value;
    logic                      cnt_start;
    logic                      cnt_step;
    logic                      cnt_done;
    logic                      cnt_busy;

    sample_stream_if u_stream ();

    assign desc.len       = i_desc_len;
    assign desc.base_addr = i_desc_base;

    burst_counter #(
        .NB_COUNT ($bits(dispatch_pkg::count_t))
    ) u_burst_counter (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (cnt_start),
        .i_enable    (i_enable),
        .i_max_count (cnt_max),
        .o_count     (cnt_value),
        .o_step      (cnt_step),
        .o_done      (cnt_done),
        .o_busy      (cnt_busy)
    );

    dispatch_fsm u_dispatch_fsm (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_enable     (i_enable),
        .i_desc_valid (i_desc_valid),
        .i_desc_skip  (i_desc_skip),
        .i_desc       (desc),
        .o_desc_ready (o_desc_ready),
        .o_rd_addr    (rd_addr),
        .o_cnt_start  (cnt_start),
        .o_cnt_max    (cnt_max),
        .i_cnt_value  (cnt_value),
        .i_cnt_step   (cnt_step),
        .i_cnt_done   (cnt_done),
        .i_cnt_busy   (cnt_busy),
        .o_stream     (u_stream.ctrl)
    );

    banked_sample_mem #(
        .N_MEM (`DISP_N_MEM)
    ) u_banked_sample_mem (
        .i_clk     (i_clk),
        .i_wr_en   (i_wr_en),
        .i_wr_sel  (i_wr_sel),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_addr (rd_addr),
        .o_stream  (u_stream.mem)
    );

    // Stream leaves the design as plain ports
    assign o_data        = u_stream.data;
    assign o_valid       = u_stream.valid;
    assign o_last        = u_stream.last;
    assign o_count_value = u_stream.count;

endmodule

//--- hw/sample_stream_if.sv
`timescale 1ns/1ps

interface sample_stream_if;

    dispatch_pkg::sample_t data;
    logic                  valid;
    logic                  last;
    dispatch_pkg::count_t  count;

    // Flags come from the FSM, the word from the memory
    modport ctrl (
        output valid,
        output last,
        output count
    );

    modport mem (
        output data
    );

    modport sink (
        input data,
        input valid,
        input last,
        input count
    );

endinterface

//--- memory_data_dispatcher.f
+incdir+hw
hw/dispatch_pkg.sv
hw/sample_stream_if.sv
hw/burst_counter.sv
hw/dispatch_fsm.sv
hw/banked_sample_mem.sv
hw/memory_data_dispatcher.sv
tests/tb_memory_data_dispatcher.sv

//--- tests/tb_memory_data_dispatcher.sv
`timescale 1ns/1ps

`include "dispatch_consts.svh"

module tb_memory_data_dispatcher;

    localparam int CLK_PERIOD = 40;
    localparam int DEPTH      = 1 << `DISP_NB_ADDR;
    localparam int NB_SEL     = `DISP_NB_BANK_SEL;
    localparam int NUM_ROWS   = 8;
    localparam int PAUSE_LEN  = 3;

    typedef struct {
        dispatch_pkg::len_t  len;
        dispatch_pkg::addr_t base;
        bit                  skip;
        int                  drop;                          // Pause start in cycles when nonzero
        bit                  early;                         // Offered while the previous burst runs
    } row_t;

    logic                  i_clk;
    logic                  i_rst;
    logic                  i_enable;
    logic                  i_desc_valid;
    logic                  i_desc_skip;
    dispatch_pkg::len_t    i_desc_len;
    dispatch_pkg::addr_t   i_desc_base;
    logic                  o_desc_ready;
    logic                  i_wr_en;
    logic [NB_SEL-1:0]     i_wr_sel;
    dispatch_pkg::addr_t   i_wr_addr;
    dispatch_pkg::word_t   i_wr_data;
    dispatch_pkg::sample_t o_data;
    logic                  o_valid;
    logic                  o_last;
    dispatch_pkg::count_t  o_count_value;

    row_t                  rows [NUM_ROWS];
    dispatch_pkg::word_t   model_mem [`DISP_N_MEM][DEPTH];
    dispatch_pkg::sample_t exp_data_q [$];
    dispatch_pkg::count_t  exp_count_q [$];
    bit                    exp_last_q [$];
    int                    exp_edge_q [$];
    int                    edge_cnt       = 0;
    int                    last_seen_edge = 0;
    int                    timeout_cycles = 0;
    int                    errors         = 0;
    int                    words_seen     = 0;
    logic                  en_at_edge     = 1'b0;

    memory_data_dispatcher i_memory_data_dispatcher (.*);

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        edge_cnt   <= edge_cnt + 1;                         // Falling edge sees last edge plus one
        en_at_edge <= i_enable;
    end

    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge i_clk);
        $display("Timeout after %0d cycles, the bursts never completed", timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic note_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic check_sample(input string name, input dispatch_pkg::sample_t got,
                                input dispatch_pkg::sample_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input dispatch_pkg::count_t got,
                               input dispatch_pkg::count_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic set_row(input int idx, input int len, input int base, input bit skip,
                           input int drop, input bit early);
        rows[idx].len   = dispatch_pkg::len_t'(len);
        rows[idx].base  = dispatch_pkg::addr_t'(base);
        rows[idx].skip  = skip;
        rows[idx].drop  = drop;
        rows[idx].early = early;
    endtask

    // Word k of a burst shows in the cycle after edge T+2+k
    task automatic push_burst(input row_t row, input int accept_edge);
        dispatch_pkg::sample_t s;
        int                    addr;
        for (int k = 0; k <= int'(row.len); k++) begin
            addr = (int'(row.base) + k) % DEPTH;
            for (int b = 0; b < `DISP_N_MEM; b++) begin
                s[b] = model_mem[b][addr];
            end
            exp_data_q.push_back(s);
            exp_count_q.push_back(dispatch_pkg::count_t'(k));
            exp_last_q.push_back(k == int'(row.len));
            exp_edge_q.push_back((row.drop > 0) ? -1 : accept_edge + 3 + k);
        end
    endtask

    task automatic wait_idle();
        while (exp_data_q.size() != 0) @(posedge i_clk);
    endtask

    // ************************************************************************
    // Output monitor
    // ************************************************************************

    always @(negedge i_clk) begin : monitor
        dispatch_pkg::sample_t d;
        dispatch_pkg::count_t  c;
        bit                    l;
        int                    e;
        if (!i_rst) begin
            if (!en_at_edge) begin
                check_bit("o_valid", o_valid, 1'b0);        // Paused counter starts no word
            end
            if (o_valid && (exp_data_q.size() == 0)) begin
                note_failure("A valid word came out with no burst pending");
            end else if (o_valid) begin
                d = exp_data_q.pop_front();
                c = exp_count_q.pop_front();
                l = exp_last_q.pop_front();
                e = exp_edge_q.pop_front();
                if ((e >= 0) && (e != edge_cnt)) begin
                    note_failure($sformatf("Word %0d came after edge %0d, not %0d",
                                           c, edge_cnt - 1, e - 1));
                end
                check_sample("o_data", o_data, d);
                check_count("o_count_value", o_count_value, c);
                check_bit("o_last", o_last, l);
                if (l) begin
                    last_seen_edge = edge_cnt;
                end
                words_seen++;
            end else begin
                check_bit("o_last", o_last, 1'b0);
            end
        end
    end

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    initial begin : stimulus
        int seed;
        int accept_edge;
        int prev_accept;
        int exp_accept;
        seed = 32'hd555;
        void'($urandom(seed));
        // Columns are row, len, base, skip, drop cycle, early offer
        set_row(0, 3, 0, 0, 0, 0);
        set_row(1, 7, 10, 0, 0, 1);
        set_row(2, 5, 60, 0, 0, 1);                         // Wraps past address 63
        set_row(3, 4, 20, 1, 0, 0);
        set_row(4, 2, 33, 0, 0, 0);
        set_row(5, 9, 40, 0, 4, 0);
        set_row(6, 0, 63, 0, 0, 1);
        set_row(7, 63, 50, 0, 0, 0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            timeout_cycles += int'(rows[r].len) + 4;
        end
        timeout_cycles = 2 * (timeout_cycles + DEPTH * `DISP_N_MEM);
        i_rst        = 1'b1;
        i_enable     = 1'b1;
        i_desc_valid = 1'b0;
        i_desc_skip  = 1'b0;
        i_desc_len   = '0;
        i_desc_base  = '0;
        i_wr_en      = 1'b0;
        i_wr_sel     = '0;
        i_wr_addr    = '0;
        i_wr_data    = '0;
        prev_accept  = 0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);
        check_bit("o_valid", o_valid, 1'b0);
        check_bit("o_last", o_last, 1'b0);
        check_bit("o_desc_ready", o_desc_ready, 1'b1);
        i_enable = 1'b0;
        @(negedge i_clk);
        check_bit("o_desc_ready", o_desc_ready, 1'b0);      // Ready follows enable in IDLE
        i_enable = 1'b1;
        for (int a = 0; a < DEPTH; a++) begin
            for (int b = 0; b < `DISP_N_MEM; b++) begin
                i_wr_en         = 1'b1;
                i_wr_sel        = NB_SEL'(b);
                i_wr_addr       = dispatch_pkg::addr_t'(a);
                i_wr_data       = dispatch_pkg::word_t'($urandom);
                model_mem[b][a] = i_wr_data;
                @(negedge i_clk);
            end
        end
        i_wr_en = 1'b0;
        @(posedge i_clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!rows[r].early) begin
                wait_idle();
            end
            @(negedge i_clk);
            i_desc_valid = 1'b1;
            i_desc_len   = rows[r].len;
            i_desc_base  = rows[r].base;
            i_desc_skip  = rows[r].skip;
            @(posedge i_clk);
            while (!o_desc_ready) @(posedge i_clk);
            accept_edge = edge_cnt;
            if (r > 0) begin
                exp_accept = rows[r-1].skip ? prev_accept + 2 : last_seen_edge + 1;
                if (accept_edge != exp_accept) begin
                    note_failure($sformatf("Row %0d was accepted at edge %0d, not at edge %0d",
                                           r, accept_edge, exp_accept));
                end
            end
            if (!rows[r].skip) begin
                push_burst(rows[r], accept_edge);
            end
            prev_accept = accept_edge;
            @(negedge i_clk);
            check_bit("o_desc_ready", o_desc_ready, rows[r].skip);
            i_desc_valid = 1'b0;
            if (rows[r].drop > 0) begin
                repeat (rows[r].drop - 1) @(negedge i_clk);
                i_enable = 1'b0;
                repeat (PAUSE_LEN) @(negedge i_clk);
                i_enable = 1'b1;
            end
            @(posedge i_clk);
        end
        wait_idle();
        repeat (8) @(posedge i_clk);                        // Catches any stray word
        $display("Run finished with %0d words checked and %0d errors", words_seen, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
